//--- bench/bpred_patterns.txt
// Inputs:   redirect redirect_pc update update_addr actual_target branch_taken
// Expected: fetch_valid fetch_pc pred_valid pred_taken pred_target
0 00000000 0 00000000 00000000 0  1 00001000 0 0 00000000  // Cold start fetch at reset_pc.
0 00000000 0 00000000 00000000 0  0 00001000 1 0 00001004  // Cold miss falls through.
0 00000000 1 00001008 00002000 1  1 00001004 0 0 00000000  // Taken update trains 1008.
0 00000000 0 00000000 00000000 0  0 00001004 1 0 00001008  // Fall-through to 1008.
0 00000000 0 00000000 00000000 0  1 00001008 0 0 00000000  // Fetch of trained branch.
0 00000000 0 00000000 00000000 0  0 00001008 1 1 00002000  // Predicted taken to 2000.
0 00000000 0 00000000 00000000 0  1 00002000 0 0 00000000  // Fetch at the target.
0 00000000 1 00001008 00002000 1  0 00002000 1 0 00002004  // Second taken update gives strong_taken.
1 00001008 0 00000000 00000000 0  1 00002004 0 0 00000000  // Redirect in issue.
0 00000000 0 00000000 00000000 0  1 00001008 0 0 00000000  // Fetch from redirect_pc.
0 00000000 1 00001008 00000000 0  0 00001008 1 1 00002000  // First not-taken update.
0 00000000 0 00000000 00000000 0  1 00002000 0 0 00000000  // Fetch at the target.
1 00001008 0 00000000 00000000 0  0 00002000 0 0 00000000  // Redirect in wait_pred squashes pred_valid.
0 00000000 0 00000000 00000000 0  1 00001008 0 0 00000000  // Fetch from redirect_pc.
0 00000000 1 00001008 00000000 0  0 00001008 1 1 00002000  // Weak taken keeps old target.
1 00001008 0 00000000 00000000 0  1 00002000 0 0 00000000  // Back to 1008.
0 00000000 0 00000000 00000000 0  1 00001008 0 0 00000000  // Refetch after two not-taken updates.
0 00000000 0 00000000 00000000 0  0 00001008 1 0 0000100c  // BTB hit but counter says not taken.
0 00000000 1 00001008 00002000 1  1 0000100c 0 0 00000000  // Shared counter back to weak_taken.
0 00000000 0 00000000 00000000 0  0 0000100c 1 0 00001010  // Untrained entry.
1 00003008 0 00000000 00000000 0  1 00001010 0 0 00000000  // Jump to an aliasing address.
0 00000000 0 00000000 00000000 0  1 00003008 0 0 00000000  // Same index with another tag.
0 00000000 0 00000000 00000000 0  0 00003008 1 0 0000300c  // Tag mismatch predicts not taken.
0 00000000 1 0000300c 00004000 1  1 0000300c 0 0 00000000  // Update on the lookup cycle.
0 00000000 0 00000000 00000000 0  0 0000300c 1 0 00003010  // Lookup saw the old contents.
1 0000300c 0 00000000 00000000 0  1 00003010 0 0 00000000  // Back to 300c.
0 00000000 0 00000000 00000000 0  1 0000300c 0 0 00000000  // Refetch of the updated entry.
0 00000000 0 00000000 00000000 0  0 0000300c 1 1 00004000  // Update now visible.
0 00000000 0 00000000 00000000 0  1 00004000 0 0 00000000  // Fetch at the new target.
0 00000000 0 00000000 00000000 0  0 00004000 1 0 00004004  // Index 00 still empty.
0 00000000 0 00000000 00000000 0  1 00004004 0 0 00000000  // Sequential fetch resumes.

//--- bpred.f
verilog/bpred_pkg.sv
verilog/branch_target_buffer.sv
verilog/direction_predictor.sv
verilog/fetch_pc_gen.sv
verilog/branch_predictor.sv
bench/bpred_checker.sv
bench/bpred_tb.sv

//--- run_bpred.sh
#!/bin/sh
# Builds the branch predictor testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module bpred_tb \
  -Mdir obj_dir -o bpred_sim \
  -f bpred.f

./obj_dir/bpred_sim > bpred_sim.log 2>&1
cat bpred_sim.log

# The testbench reports its verdict in the log.
if grep -q "SIMULATION FAILED" bpred_sim.log; then
  echo "Testbench reported a failure, see bpred_sim.log."
  exit 1
fi
exit 0

//--- bench/bpred_tb.sv
module bpred_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Bench timing in ns.
  localparam int half_period  = 50;
  localparam int drive_delay  = 10;
  localparam int reset_cycles = 4;
  // Cycles allowed for the first fetch after reset.
  localparam int start_timeout = 20;
  // Six inputs and five expected outputs per pattern line.
  localparam int    field_count  = 11;
  // Vectors in the pattern file, one per cycle of the sequence.
  localparam int    vector_count = 31;
  localparam string pattern_path = "bench/bpred_patterns.txt";

  logic clk = 1'b0;
  logic reset;

  // DUT inputs.
  logic                            redirect;
  logic [bpred_pkg::addr_width-1:0] redirect_pc;
  logic                            update;
  logic [bpred_pkg::addr_width-1:0] update_addr;
  logic [bpred_pkg::addr_width-1:0] actual_target;
  logic                            branch_taken;

  // DUT outputs.
  logic                            fetch_valid;
  logic [bpred_pkg::addr_width-1:0] fetch_pc;
  logic                            pred_valid;
  logic                            pred_taken;
  logic [bpred_pkg::addr_width-1:0] pred_target;

  // Expected outputs for the cycle being driven.
  logic                            exp_fetch_valid;
  logic [bpred_pkg::addr_width-1:0] exp_fetch_pc;
  logic                            exp_pred_valid;
  logic                            exp_pred_taken;
  logic [bpred_pkg::addr_width-1:0] exp_pred_target;
  logic                            check_en;

  int mismatch_count;
  int other_failures;

  always #half_period clk = ~clk;

  branch_predictor #(
    .btb_index_bits (8),
    .pht_index_bits (8)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .update        (update),
    .update_addr   (update_addr),
    .actual_target (actual_target),
    .branch_taken  (branch_taken),
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .pred_valid    (pred_valid),
    .pred_taken    (pred_taken),
    .pred_target   (pred_target)
  );

  bpred_checker u_checker (
    .clk             (clk),
    .check_en        (check_en),
    .fetch_valid     (fetch_valid),
    .fetch_pc        (fetch_pc),
    .pred_valid      (pred_valid),
    .pred_taken      (pred_taken),
    .pred_target     (pred_target),
    .exp_fetch_valid (exp_fetch_valid),
    .exp_fetch_pc    (exp_fetch_pc),
    .exp_pred_valid  (exp_pred_valid),
    .exp_pred_taken  (exp_pred_taken),
    .exp_pred_target (exp_pred_target),
    .error_count     (mismatch_count)
  );

  // Idle values for every DUT input.
  task automatic clear_inputs;
    redirect      = 1'b0;
    redirect_pc   = '0;
    update        = 1'b0;
    update_addr   = '0;
    actual_target = '0;
    branch_taken  = 1'b0;
  endtask

  // Reset held over four rising edges, released off the edge.
  task automatic apply_reset;
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
  endtask

  // Lines of only whitespace or starting with a slash carry no vector.
  function automatic bit blank_or_comment(input string text);
    byte c;
    for (int i = 0; i < text.len(); i++) begin
      c = text[i];
      if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
        return (c == "/");
      end
    end
    return 1'b1;
  endfunction

  // Aligns the first pattern line with an issue cycle.
  task automatic wait_first_fetch(output bit seen);
    int cycles;
    cycles = 0;
    while (!fetch_valid && cycles < start_timeout) begin
      @(posedge clk);
      #drive_delay;
      cycles++;
    end
    seen = fetch_valid;
  endtask

  // One pattern line per clock cycle.
  task automatic run_patterns(input int fd);
    string line;
    int    line_no;
    int    fields;
    int    vectors;
    bit    stop;
    logic [31:0] v_redirect, v_redirect_pc, v_update, v_update_addr, v_target, v_taken;
    logic [31:0] v_fetch_valid, v_fetch_pc, v_pred_valid, v_pred_taken, v_pred_target;
    line_no = 0;
    vectors = 0;
    stop    = 1'b0;
    while (!stop && !$feof(fd)) begin
      line = "";
      fields = $fgets(line, fd);
      line_no++;
      if (!blank_or_comment(line)) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                         v_redirect, v_redirect_pc, v_update, v_update_addr, v_target,
                         v_taken, v_fetch_valid, v_fetch_pc, v_pred_valid, v_pred_taken,
                         v_pred_target);
        if (fields != field_count) begin
          $display("Pattern line %0d holds %0d of %0d fields and cannot be applied.",
                   line_no, fields, field_count);
          other_failures++;
          stop = 1'b1;
        end else begin
          // First vector goes into the cycle found by the start wait.
          if (vectors > 0) begin
            @(posedge clk);
            #drive_delay;
          end
          redirect        = v_redirect[0];
          redirect_pc     = v_redirect_pc;
          update          = v_update[0];
          update_addr     = v_update_addr;
          actual_target   = v_target;
          branch_taken    = v_taken[0];
          exp_fetch_valid = v_fetch_valid[0];
          exp_fetch_pc    = v_fetch_pc;
          exp_pred_valid  = v_pred_valid[0];
          exp_pred_taken  = v_pred_taken[0];
          exp_pred_target = v_pred_target;
          check_en        = 1'b1;
          vectors++;
        end
      end
    end
    // Let the checker sample the last vector.
    if (vectors > 0) begin
      @(posedge clk);
      #drive_delay;
    end
    check_en = 1'b0;
    clear_inputs();
    if (!stop && vectors < vector_count) begin
      $display("Pattern file %s ends after %0d of %0d test vectors.",
               pattern_path, vectors, vector_count);
      other_failures++;
    end
  endtask

  task automatic report_and_finish;
    int total;
    total = mismatch_count + other_failures;
    $display("Value errors: %0d, other failures: %0d, total errors: %0d",
             mismatch_count, other_failures, total);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin
    int fd;
    bit started;
    other_failures  = 0;
    check_en        = 1'b0;
    exp_fetch_valid = 1'b0;
    exp_fetch_pc    = '0;
    exp_pred_valid  = 1'b0;
    exp_pred_taken  = 1'b0;
    exp_pred_target = '0;
    clear_inputs();
    reset = 1'b1;
    fd = $fopen(pattern_path, "r");
    apply_reset();
    if (fd == 0) begin
      $display("Cannot open pattern file %s.", pattern_path);
      other_failures++;
    end else begin
      wait_first_fetch(started);
      if (!started) begin
        $display("Timed out after %0d cycles waiting for the first fetch_valid after reset.",
                 start_timeout);
        other_failures++;
      end else begin
        run_patterns(fd);
      end
      $fclose(fd);
    end
    report_and_finish();
  end

endmodule

//--- bench/bpred_checker.sv
module bpred_checker (
  input  logic                            clk,
  // Compare only while the bench drives patterns.
  input  logic                            check_en,
  // Observed DUT outputs.
  input  logic                            fetch_valid,
  input  logic [bpred_pkg::addr_width-1:0] fetch_pc,
  input  logic                            pred_valid,
  input  logic                            pred_taken,
  input  logic [bpred_pkg::addr_width-1:0] pred_target,
  // Expected outputs for the same cycle.
  input  logic                            exp_fetch_valid,
  input  logic [bpred_pkg::addr_width-1:0] exp_fetch_pc,
  input  logic                            exp_pred_valid,
  input  logic                            exp_pred_taken,
  input  logic [bpred_pkg::addr_width-1:0] exp_pred_target,
  // Running count of wrong values.
  output int                              error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  int errors = 0;

  assign error_count = errors;

  // Single-bit compare.
  // X or Z on the DUT side counts as wrong.
  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  // Address compare.
  task automatic compare_word(
    input string                            name,
    input logic [bpred_pkg::addr_width-1:0] expected,
    input logic [bpred_pkg::addr_width-1:0] actual
  );
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Outputs settle after the drive point and hold until this edge.
  always @(posedge clk) begin
    if (check_en) begin
      compare_bit("fetch_valid", exp_fetch_valid, fetch_valid);
      compare_word("fetch_pc", exp_fetch_pc, fetch_pc);
      // Prediction fields are zero outside a valid cycle.
      compare_bit("pred_valid", exp_pred_valid, pred_valid);
      compare_bit("pred_taken", exp_pred_taken, pred_taken);
      compare_word("pred_target", exp_pred_target, pred_target);
    end
  end

endmodule

//--- verilog/branch_predictor.sv
module branch_predictor #(
  parameter int btb_index_bits = 8,
  parameter int pht_index_bits = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  // Fetch restart.
  input  logic                            redirect,
  input  logic [bpred_pkg::addr_width-1:0] redirect_pc,
  // Resolved branch update.
  input  logic                            update,
  input  logic [bpred_pkg::addr_width-1:0] update_addr,
  input  logic [bpred_pkg::addr_width-1:0] actual_target,
  input  logic                            branch_taken,
  // Fetch stream.
  output logic                            fetch_valid,
  output logic [bpred_pkg::addr_width-1:0] fetch_pc,
  // Prediction stream, one cycle behind fetch.
  output logic                            pred_valid,
  output logic                            pred_taken,
  output logic [bpred_pkg::addr_width-1:0] pred_target
);

  // Registered table results.
  logic                            hit;
  logic [bpred_pkg::addr_width-1:0] hit_target;
  logic                            counter_taken;

  // Sequencer and next-PC choice.
  // The fetch address doubles as the lookup address for both tables.
  fetch_pc_gen u_fetch_pc_gen (
    .clk           (clk),
    .reset         (reset),
    .hit           (hit),
    .hit_target    (hit_target),
    .counter_taken (counter_taken),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .pred_valid    (pred_valid),
    .pred_taken    (pred_taken),
    .pred_target   (pred_target)
  );

  // Target store.
  branch_target_buffer #(
    .btb_index_bits (btb_index_bits)
  ) u_branch_target_buffer (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .hit           (hit),
    .hit_target    (hit_target),
    .update        (update),
    .branch_taken  (branch_taken),
    .update_addr   (update_addr),
    .actual_target (actual_target)
  );

  // Direction counters, sharing the same update strobe.
  direction_predictor #(
    .pht_index_bits (pht_index_bits)
  ) u_direction_predictor (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (fetch_pc),
    .counter_taken (counter_taken),
    .update        (update),
    .branch_taken  (branch_taken),
    .update_addr   (update_addr)
  );

endmodule

//--- verilog/fetch_pc_gen.sv
module fetch_pc_gen (
  input  logic                            clk,
  input  logic                            reset,
  // Table results, one cycle after the fetch.
  input  logic                            hit,
  input  logic [bpred_pkg::addr_width-1:0] hit_target,
  input  logic                            counter_taken,
  // Restart request from outside.
  input  logic                            redirect,
  input  logic [bpred_pkg::addr_width-1:0] redirect_pc,
  // Fetch strobe, also the table lookup request.
  output logic                            fetch_valid,
  output logic [bpred_pkg::addr_width-1:0] fetch_pc,
  // Prediction for the last fetch.
  output logic                            pred_valid,
  output logic                            pred_taken,
  output logic [bpred_pkg::addr_width-1:0] pred_target
);

  // Sequential instruction step in bytes.
  localparam logic [bpred_pkg::addr_width-1:0] fetch_step = 4;

  bpred_pkg::fetch_state_t state;

  // Current fetch address.
  logic [bpred_pkg::addr_width-1:0] pc;

  // Fall-through and chosen next address.
  logic [bpred_pkg::addr_width-1:0] fall_through;
  logic [bpred_pkg::addr_width-1:0] next_target;

  // BTB hit qualified by the direction counter.
  logic take_branch;

  // PC still holds the fetched address while the results come back.
  assign fetch_valid  = (state == bpred_pkg::issue);
  assign fetch_pc     = pc;
  assign fall_through = pc + fetch_step;

  // Taken only when the target is known and the counter agrees.
  assign take_branch = hit && counter_taken;
  assign next_target = take_branch ? hit_target : fall_through;

  // A redirect squashes the prediction in flight.
  assign pred_valid  = (state == bpred_pkg::wait_pred) && !redirect;
  // Prediction outputs read zero outside a valid cycle.
  assign pred_taken  = pred_valid && take_branch;
  assign pred_target = pred_valid ? next_target : '0;

  // Issue/wait sequencer and PC register.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= bpred_pkg::issue;
      pc    <= bpred_pkg::reset_pc;
    end else if (redirect) begin
      // Redirect wins in either state.
      state <= bpred_pkg::issue;
      pc    <= redirect_pc;
    end else begin
      case (state)
        bpred_pkg::issue: begin
          state <= bpred_pkg::wait_pred;
        end
        bpred_pkg::wait_pred: begin
          state <= bpred_pkg::issue;
          pc    <= next_target;
        end
        default: state <= bpred_pkg::issue;
      endcase
    end
  end

endmodule

//--- verilog/direction_predictor.sv
module direction_predictor #(
  parameter int pht_index_bits = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  // Lookup side, driven by the fetch address.
  input  logic [bpred_pkg::addr_width-1:0] lookup_pc,
  output logic                            counter_taken,
  // Update side, driven by resolved branches.
  input  logic                            update,
  input  logic                            branch_taken,
  input  logic [bpred_pkg::addr_width-1:0] update_addr
);

  // One counter per entry, indexed by the low address bits.
  localparam int entries = 2 ** pht_index_bits;

  // Pattern history table.
  bpred_pkg::counter_t pht [entries];

  // Table indices.
  logic [pht_index_bits-1:0] lookup_index;
  logic [pht_index_bits-1:0] update_index;

  // Counter at the lookup index.
  bpred_pkg::counter_t lookup_count;

  // Counter at the update index after one step.
  bpred_pkg::counter_t next_count;

  // Moves a counter one step toward the outcome.
  // Both ends saturate.
  function automatic bpred_pkg::counter_t step_counter(
    input bpred_pkg::counter_t count,
    input logic                taken
  );
    bpred_pkg::counter_t stepped;
    stepped = count;
    case (count)
      bpred_pkg::strong_not_taken: begin
        if (taken) stepped = bpred_pkg::weak_not_taken;
      end
      bpred_pkg::weak_not_taken: begin
        stepped = taken ? bpred_pkg::weak_taken : bpred_pkg::strong_not_taken;
      end
      bpred_pkg::weak_taken: begin
        stepped = taken ? bpred_pkg::strong_taken : bpred_pkg::weak_not_taken;
      end
      bpred_pkg::strong_taken: begin
        if (!taken) stepped = bpred_pkg::weak_taken;
      end
      default: stepped = bpred_pkg::weak_not_taken;
    endcase
    return stepped;
  endfunction

  assign lookup_index = lookup_pc[pht_index_bits-1:0];
  assign update_index = update_addr[pht_index_bits-1:0];

  assign lookup_count = pht[lookup_index];
  assign next_count   = step_counter(pht[update_index], branch_taken);

  // Registered lookup.
  // Upper half of the counter range predicts taken.
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_taken <= 1'b0;
    end else begin
      counter_taken <= lookup_count inside {bpred_pkg::weak_taken, bpred_pkg::strong_taken};
    end
  end

  // Counter update.
  // Every entry starts weakly not taken.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < entries; i++) begin
        pht[i] <= bpred_pkg::weak_not_taken;
      end
    end else if (update) begin
      pht[update_index] <= next_count;
    end
  end

endmodule

//--- verilog/branch_target_buffer.sv
module branch_target_buffer #(
  parameter int btb_index_bits = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  // Lookup side, driven by the fetch address.
  input  logic [bpred_pkg::addr_width-1:0] lookup_pc,
  output logic                            hit,
  output logic [bpred_pkg::addr_width-1:0] hit_target,
  // Update side, driven by resolved branches.
  input  logic                            update,
  input  logic                            branch_taken,
  input  logic [bpred_pkg::addr_width-1:0] update_addr,
  input  logic [bpred_pkg::addr_width-1:0] actual_target
);

  // Direct-mapped geometry.
  localparam int entries  = 2 ** btb_index_bits;
  // Tag is every address bit above the index.
  localparam int tag_bits = bpred_pkg::addr_width - btb_index_bits;

  // One valid bit per entry.
  logic [entries-1:0] valid;

  // Tag and target storage.
  logic [tag_bits-1:0]             tag_mem    [entries];
  logic [bpred_pkg::addr_width-1:0] target_mem [entries];

  // Lookup address split.
  logic [btb_index_bits-1:0] lookup_index;
  logic [tag_bits-1:0]       lookup_tag;

  // Update address split.
  logic [btb_index_bits-1:0] update_index;
  logic [tag_bits-1:0]       update_tag;

  // Entry hit before the result register.
  logic entry_match;

  // Only a taken branch allocates or refreshes an entry.
  logic write_entry;

  // Low bits pick the entry.
  assign lookup_index = lookup_pc[btb_index_bits-1:0];
  // High bits must match the stored tag.
  assign lookup_tag   = lookup_pc[bpred_pkg::addr_width-1:btb_index_bits];

  // Same split on the update address.
  assign update_index = update_addr[btb_index_bits-1:0];
  assign update_tag   = update_addr[bpred_pkg::addr_width-1:btb_index_bits];

  // A hit needs a valid entry with a matching tag.
  // An address that aliases on the index but differs in the tag misses.
  assign entry_match = valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);

  // Not-taken outcomes leave the entry alone.
  // The direction counter handles those instead.
  assign write_entry = update && branch_taken;

  // Registered lookup, one cycle from address to result.
  // Reads see the contents before any same-edge update.
  always_ff @(posedge clk) begin
    if (reset) begin
      hit        <= 1'b0;
      hit_target <= '0;
    end else begin
      hit <= entry_match;
      // Target reads as zero on a miss.
      if (entry_match) begin
        hit_target <= target_mem[lookup_index];
      end else begin
        hit_target <= '0;
      end
    end
  end

  // Valid bits.
  // Cleared together on reset, set by a taken update.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (write_entry) begin
      valid[update_index] <= 1'b1;
    end
  end

  // Tag and target write.
  // Stale contents are masked by the valid bit.
  always_ff @(posedge clk) begin
    if (write_entry) begin
      tag_mem[update_index]    <= update_tag;
      target_mem[update_index] <= actual_target;
    end
  end

endmodule

//--- verilog/bpred_pkg.sv
package bpred_pkg;

  // Width of every fetch address and branch target.
  parameter int addr_width = 32;

  // First fetch address after reset.
  parameter logic [addr_width-1:0] reset_pc = 32'h0000_1000;

  // Two-bit saturating direction counter.
  // The upper half of the range predicts taken.
  // Reset value is weak_not_taken.
  typedef enum logic [1:0] {
    // Saturated toward not taken.
    strong_not_taken = 2'b00,
    // One taken update away from predicting taken.
    weak_not_taken   = 2'b01,
    // One not-taken update away from predicting not taken.
    weak_taken       = 2'b10,
    // Saturated toward taken.
    strong_taken     = 2'b11
  } counter_t;

  // Fetch PC generator sequence.
  // A fetch is issued, then its prediction is formed one cycle later.
  typedef enum logic {
    // Fetch address is presented to the tables.
    issue     = 1'b0,
    // Table results are back, next PC is chosen.
    wait_pred = 1'b1
  } fetch_state_t;

endpackage
